// ==== ice_app_pkg.sv ====
package ice_app_pkg;

    // =========================================================================
    // Message format
    // =========================================================================

    localparam int MSG_LEN      = 64;
    localparam int MSG_TYPE_LEN = 8;
    localparam int MSG_ARG_LEN  = MSG_LEN - MSG_TYPE_LEN;

    // 16 nibbles of message plus the 2-nibble dummy lead byte
    localparam int MSG_CYCLES = (MSG_LEN / 4) + 2;

    // Echo returns every argument byte
    localparam int RESP_BYTES = MSG_ARG_LEN / 8;

    typedef logic [MSG_LEN-1:0]      msg_t;
    typedef logic [MSG_TYPE_LEN-1:0] msg_type_t;
    typedef logic [MSG_ARG_LEN-1:0]  msg_arg_t;
    typedef logic [7:0]              byte_t;

    // Bit 7 of the type marks commands that expect a response
    localparam msg_type_t MSG_TYPE_NOP        = 8'h00;
    localparam msg_type_t MSG_TYPE_SD_READOUT = 8'h01;
    localparam msg_type_t MSG_TYPE_ECHO       = 8'h80;

    // =========================================================================
    // Readout buffering
    // =========================================================================

    localparam int FIFO_DEPTH = 256;
    localparam int CHUNK_LEN  = 128;
    localparam int CHUNK_GAP  = 2;

    // One extra bit tells a full FIFO from an empty one
    typedef logic [$clog2(FIFO_DEPTH):0] fifo_ptr_t;

    typedef enum logic [2:0] {
        MSG_IN,
        DECODE,
        RESP_OUT,
        READOUT_WAIT,
        READOUT_STREAM,
        READOUT_GAP,
        IDLE
    } spi_state_t;

    // Prefixed so the labels do not clash with spi_state_t
    typedef enum logic [1:0] {
        PROD_IDLE,
        PROD_WAIT_ROOM,
        PROD_WRITE
    } prod_state_t;

endpackage

// ==== afifo.sv ====
`timescale 1ns/10ps

module afifo (
    // Write side
    input  logic                w_clk,
    input  logic                w_rst_n,
    input  logic                w_en,
    input  ice_app_pkg::byte_t  w_data,
    output logic                w_chunk_room,

    // Read side
    input  logic                r_clk,
    input  logic                r_rst_n,
    input  logic                r_en,
    output ice_app_pkg::byte_t  r_data,
    output logic                r_chunk_ready
);
    import ice_app_pkg::*;

    function automatic fifo_ptr_t bin2gray(fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic fifo_ptr_t gray2bin(fifo_ptr_t g);
        fifo_ptr_t b;
        b[$bits(fifo_ptr_t)-1] = g[$bits(fifo_ptr_t)-1];
        for (int i = $bits(fifo_ptr_t) - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    byte_t     mem [FIFO_DEPTH];

    fifo_ptr_t wbin, wgray, wbin_next;
    fifo_ptr_t rbin, rgray, rbin_next;

    // Gray pointers after crossing into the other domain
    fifo_ptr_t rgray_w1, rgray_w2;
    fifo_ptr_t wgray_r1, wgray_r2;

    fifo_ptr_t w_fill, r_fill;

    assign wbin_next = wbin + fifo_ptr_t'(1);
    assign rbin_next = rbin + fifo_ptr_t'(1);

    // =========================================================================
    // Write domain
    // =========================================================================

    always_ff @(posedge w_clk or negedge w_rst_n) begin
        if (!w_rst_n) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
            if (w_en) begin
                wbin  <= wbin_next;
                wgray <= bin2gray(wbin_next);
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_en) begin
            mem[wbin[$clog2(FIFO_DEPTH)-1:0]] <= w_data;
        end
    end

    // Stale read pointer only overstates the fill, so room is never overstated
    assign w_fill       = wbin - gray2bin(rgray_w2);
    assign w_chunk_room = (w_fill <= fifo_ptr_t'(FIFO_DEPTH - CHUNK_LEN));

    // =========================================================================
    // Read domain
    // =========================================================================

    always_ff @(posedge r_clk or negedge r_rst_n) begin
        if (!r_rst_n) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (r_en) begin
                rbin  <= rbin_next;
                rgray <= bin2gray(rbin_next);
            end
        end
    end

    // First-word-fall-through
    assign r_data = mem[rbin[$clog2(FIFO_DEPTH)-1:0]];

    assign r_fill        = gray2bin(wgray_r2) - rbin;
    assign r_chunk_ready = (r_fill >= fifo_ptr_t'(CHUNK_LEN));

endmodule

// ==== chunk_producer.sv ====
`timescale 1ns/10ps

module chunk_producer (
    input  logic                prod_clk,
    input  logic                spi_cs,
    input  logic                prod_req,
    input  logic                w_chunk_room,
    output logic                fifo_w_en,
    output ice_app_pkg::byte_t  fifo_w_data,
    output logic                prod_rst_n
);
    import ice_app_pkg::*;

    logic        rst_meta;
    logic [2:0]  req_sync;
    logic        req_edge;
    prod_state_t state;
    byte_t       wr_cnt;

    // Deselect resets at once, release waits two producer clocks
    always_ff @(posedge prod_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            rst_meta   <= 1'b0;
            prod_rst_n <= 1'b0;
        end else begin
            rst_meta   <= 1'b1;
            prod_rst_n <= rst_meta;
        end
    end

    // Toggle request from the SPI clock
    always_ff @(posedge prod_clk or negedge prod_rst_n) begin
        if (!prod_rst_n) begin
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[1:0], prod_req};
        end
    end

    assign req_edge = req_sync[2] ^ req_sync[1];

    always_ff @(posedge prod_clk or negedge prod_rst_n) begin
        if (!prod_rst_n) begin
            state  <= PROD_IDLE;
            wr_cnt <= '0;
        end else begin
            case (state)
                PROD_IDLE: begin
                    if (req_edge) state <= PROD_WAIT_ROOM;
                end
                PROD_WAIT_ROOM: begin
                    wr_cnt <= '0;
                    if (w_chunk_room) state <= PROD_WRITE;
                end
                PROD_WRITE: begin
                    wr_cnt <= wr_cnt + 8'd1;
                    if (wr_cnt == byte_t'(CHUNK_LEN - 1)) state <= PROD_WAIT_ROOM;
                end
                default: state <= PROD_IDLE;
            endcase
        end
    end

    // Counting data, restarting at zero each chunk
    assign fifo_w_en   = (state == PROD_WRITE);
    assign fifo_w_data = wr_cnt;

endmodule

// ==== spi_msg_engine.sv ====
`timescale 1ns/10ps

module spi_msg_engine (
    input  logic                ice_st_spi_clk,
    input  logic                spi_cs,
    input  ice_app_pkg::byte_t  spi_d_in,
    output ice_app_pkg::byte_t  spi_d_out,
    output logic                spi_d_oe,
    output logic                prod_req,
    output logic                fifo_r_en,
    input  ice_app_pkg::byte_t  fifo_r_data,
    input  logic                r_chunk_ready,
    output logic                data_ready
);
    import ice_app_pkg::*;

    spi_state_t state;
    logic [7:0] cnt;

    msg_t       msg;
    msg_type_t  msg_type;
    msg_arg_t   msg_arg;
    msg_arg_t   resp_sr;

    logic       chunk_sync1;
    logic       chunk_sync2;

    assign msg_type = msg[MSG_LEN-1 -: MSG_TYPE_LEN];
    assign msg_arg  = msg[MSG_ARG_LEN-1:0];

    // =========================================================================
    // Chunk-ready synchronizer
    // =========================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            chunk_sync1 <= 1'b0;
            chunk_sync2 <= 1'b0;
        end else begin
            chunk_sync1 <= r_chunk_ready;
            chunk_sync2 <= chunk_sync1;
        end
    end

    assign data_ready = chunk_sync2;

    // Pop happens on the same edge that latches the byte
    assign fifo_r_en = (state == READOUT_STREAM);

    // =========================================================================
    // Control FSM
    // =========================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            state    <= MSG_IN;
            cnt      <= '0;
            spi_d_oe <= 1'b0;
            prod_req <= 1'b0;
        end else begin
            spi_d_oe <= 1'b0;
            cnt      <= cnt + 8'd1;
            case (state)
                MSG_IN: begin
                    if (cnt == 8'(MSG_CYCLES - 1)) state <= DECODE;
                end
                DECODE: begin
                    cnt <= '0;
                    case (msg_type)
                        MSG_TYPE_ECHO:       state <= RESP_OUT;
                        MSG_TYPE_SD_READOUT: begin
                            prod_req <= ~prod_req;
                            state    <= READOUT_WAIT;
                        end
                        // Nop and anything unknown stay silent
                        default:             state <= IDLE;
                    endcase
                end
                RESP_OUT: begin
                    spi_d_oe <= 1'b1;
                    if (cnt == 8'(RESP_BYTES - 1)) state <= IDLE;
                end
                READOUT_WAIT: begin
                    cnt <= '0;
                    if (chunk_sync2) state <= READOUT_STREAM;
                end
                READOUT_STREAM: begin
                    spi_d_oe <= 1'b1;
                    if (cnt == 8'(CHUNK_LEN - 1)) begin
                        cnt   <= '0;
                        state <= READOUT_GAP;
                    end
                end
                READOUT_GAP: begin
                    // Also lets the ready flag catch up with the pops
                    if (cnt == 8'(CHUNK_GAP - 1)) state <= READOUT_WAIT;
                end
                default: cnt <= cnt;
            endcase
        end
    end

    // Data path
    always_ff @(posedge ice_st_spi_clk) begin
        case (state)
            MSG_IN:         msg <= {msg[MSG_LEN-5:0], spi_d_in[3:0]};
            DECODE:         resp_sr <= msg_arg;
            RESP_OUT: begin
                spi_d_out <= resp_sr[MSG_ARG_LEN-1 -: 8];
                resp_sr   <= resp_sr << 8;
            end
            READOUT_STREAM: spi_d_out <= fifo_r_data;
            default:        spi_d_out <= spi_d_out;
        endcase
    end

endmodule

// ==== ice_app_top.sv ====
`timescale 1ns/10ps

module ice_app_top (
    input  logic                ice_st_spi_clk,
    input  logic                spi_cs,
    input  logic                prod_clk,
    input  ice_app_pkg::byte_t  spi_d_in,
    output ice_app_pkg::byte_t  spi_d_out,
    output logic                spi_d_oe,
    output logic                spi_d_ready
);
    import ice_app_pkg::*;

    logic  prod_req;
    logic  prod_rst_n;
    logic  fifo_w_en;
    byte_t fifo_w_data;
    logic  w_chunk_room;
    logic  fifo_r_en;
    byte_t fifo_r_data;
    logic  r_chunk_ready;

    spi_msg_engine u_engine (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe),
        .prod_req       (prod_req),
        .fifo_r_en      (fifo_r_en),
        .fifo_r_data    (fifo_r_data),
        .r_chunk_ready  (r_chunk_ready),
        .data_ready     (spi_d_ready)
    );

    chunk_producer u_producer (
        .prod_clk     (prod_clk),
        .spi_cs       (spi_cs),
        .prod_req     (prod_req),
        .w_chunk_room (w_chunk_room),
        .fifo_w_en    (fifo_w_en),
        .fifo_w_data  (fifo_w_data),
        .prod_rst_n   (prod_rst_n)
    );

    // Write side resets on the producer's synchronized release
    afifo u_fifo (
        .w_clk         (prod_clk),
        .w_rst_n       (prod_rst_n),
        .w_en          (fifo_w_en),
        .w_data        (fifo_w_data),
        .w_chunk_room  (w_chunk_room),
        .r_clk         (ice_st_spi_clk),
        .r_rst_n       (spi_cs),
        .r_en          (fifo_r_en),
        .r_data        (fifo_r_data),
        .r_chunk_ready (r_chunk_ready)
    );

endmodule

// ==== ice_app_asserts.sv ====
`timescale 1ns/10ps

module ice_app_asserts (
    input logic                    ice_st_spi_clk,
    input logic                    spi_cs,
    input ice_app_pkg::spi_state_t state,
    input logic                    spi_d_oe,
    input logic                    fifo_r_en,
    input logic                    prod_req,
    input logic                    data_ready
);
    import ice_app_pkg::*;

    logic req_prev;
    logic req_toggled;

    // Number of failed assertions
    int   fail_count = 0;

    // Tracks whether prod_req has already toggled in this selection
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            req_prev    <= 1'b0;
            req_toggled <= 1'b0;
        end else begin
            req_prev    <= prod_req;
            req_toggled <= req_toggled | (prod_req != req_prev);
        end
    end

    oe_quiet_on_input: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        (state == MSG_IN || state == DECODE) |-> !spi_d_oe
    ) else begin
        $error("spi_d_oe high while a command is received or decoded");
        fail_count++;
    end

    // A chunk of pops only starts once a full chunk was flagged
    pop_needs_chunk: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        $rose(fifo_r_en) |-> $past(data_ready)
    ) else begin
        $error("FIFO pops started without a full chunk ready");
        fail_count++;
    end

    one_request: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        (prod_req != req_prev) |-> !req_toggled
    ) else begin
        $error("prod_req toggled more than once in one selection");
        fail_count++;
    end

endmodule

bind spi_msg_engine ice_app_asserts u_asserts (
    .ice_st_spi_clk (ice_st_spi_clk),
    .spi_cs         (spi_cs),
    .state          (state),
    .spi_d_oe       (spi_d_oe),
    .fifo_r_en      (fifo_r_en),
    .prod_req       (prod_req),
    .data_ready     (data_ready)
);

// ==== tb_ice_app.sv ====
`timescale 1ns/10ps

module tb_ice_app;
    import ice_app_pkg::*;

    typedef enum logic [1:0] {
        ROW_ECHO,
        ROW_SILENT,
        ROW_READOUT
    } row_kind_t;

    localparam int    NUM_ROWS     = 9;
    localparam int    SILENT_EDGES = 40;
    localparam int    START_LIMIT  = 1000;
    localparam byte_t DUMMY_BYTE   = 8'hA5;
    // At most about 1500 SPI cycles per row, plus margin
    localparam int    TIMEOUT_CYCLES = 20000;

    logic  ice_st_spi_clk;
    logic  prod_clk;
    logic  spi_cs;
    byte_t spi_d_in;
    byte_t spi_d_out;
    logic  spi_d_oe;
    logic  spi_d_ready;

    // Stimulus table, one entry per row
    msg_type_t row_type   [NUM_ROWS];
    msg_arg_t  row_arg    [NUM_ROWS];
    row_kind_t row_kind   [NUM_ROWS];
    int        row_chunks [NUM_ROWS];
    int        row_cut    [NUM_ROWS];

    integer seed;
    int     errors;
    int     checks;
    int     cycles;

    ice_app_top UUT (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .prod_clk       (prod_clk),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_oe       (spi_d_oe),
        .spi_d_ready    (spi_d_ready)
    );

    initial begin
        ice_st_spi_clk = 1'b0;
        forever #10 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    initial begin
        prod_clk = 1'b0;
        forever #5 prod_clk = ~prod_clk;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ice_st_spi_clk);
            cycles++;
        end
        $display("ERROR: simulation timed out after %0d SPI cycles", cycles);
        $display("Test failed");
        $finish;
    end

    // ========================================================================
    // Table setup
    // ========================================================================

    function automatic msg_arg_t random_arg();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[MSG_ARG_LEN-1:0];
    endfunction

    task automatic set_row(input int idx, input msg_type_t mtype, input msg_arg_t marg,
                           input row_kind_t kind, input int chunks, input int cut);
        row_type[idx]   = mtype;
        row_arg[idx]    = marg;
        row_kind[idx]   = kind;
        row_chunks[idx] = chunks;
        row_cut[idx]    = cut;
    endtask

    // A cut of -1 means the chunks run to the end
    task automatic fill_table();
        set_row(0, MSG_TYPE_ECHO,       random_arg(), ROW_ECHO,    0, -1);
        set_row(1, MSG_TYPE_ECHO,       random_arg(), ROW_ECHO,    0, -1);
        set_row(2, MSG_TYPE_NOP,        '0,           ROW_SILENT,  0, -1);
        set_row(3, 8'h42,               '0,           ROW_SILENT,  0, -1);
        set_row(4, MSG_TYPE_SD_READOUT, '0,           ROW_READOUT, 2, -1);
        set_row(5, MSG_TYPE_SD_READOUT, '0,           ROW_READOUT, 1, 60);
        set_row(6, MSG_TYPE_ECHO,       random_arg(), ROW_ECHO,    0, -1);
        set_row(7, MSG_TYPE_SD_READOUT, '0,           ROW_READOUT, 1, -1);
        set_row(8, MSG_TYPE_ECHO,       random_arg(), ROW_ECHO,    0, -1);
    endtask

    // ========================================================================
    // Host model
    // ========================================================================

    // Outputs are read at the falling edge after the rising edge that set them
    task automatic next_edge();
        @(posedge ice_st_spi_clk);
        @(negedge ice_st_spi_clk);
    endtask

    task automatic hold_deselect();
        @(posedge ice_st_spi_clk);
        spi_cs   <= 1'b0;
        spi_d_in <= '0;
        repeat (3) @(posedge ice_st_spi_clk);
    endtask

    // Called on a rising edge, returns on edge 18
    task automatic send_command(input msg_type_t mtype, input msg_arg_t marg);
        msg_t       msg;
        logic [3:0] nib;
        msg = {mtype, marg};
        spi_cs <= 1'b1;
        for (int n = 0; n < MSG_CYCLES; n++) begin
            if (n == 0) begin
                nib = DUMMY_BYTE[7:4];
            end else if (n == 1) begin
                nib = DUMMY_BYTE[3:0];
            end else begin
                nib = msg[MSG_LEN-1-4*(n-2) -: 4];
            end
            spi_d_in <= {4'h0, nib};
            @(posedge ice_st_spi_clk);
        end
        spi_d_in <= '0;
    endtask

    // ========================================================================
    // Response checks
    // ========================================================================

    task automatic expect_echo(input int r, input msg_arg_t arg);
        byte_t exp;
        // Edge 19 is the decode
        next_edge();
        for (int k = 0; k < RESP_BYTES; k++) begin
            next_edge();
            exp = arg[MSG_ARG_LEN-1-8*k -: 8];
            checks++;
            if (spi_d_oe !== 1'b1 || spi_d_out !== exp) begin
                errors++;
                $display("MISMATCH at %0t: row %0d echo byte %0d got oe=%b data=%h, expected %h",
                         $time, r, k, spi_d_oe, spi_d_out, exp);
            end
        end
        for (int k = 0; k < 8; k++) begin
            next_edge();
            checks++;
            if (spi_d_oe !== 1'b0) begin
                errors++;
                $display("MISMATCH at %0t: row %0d spi_d_oe still high after the echo",
                         $time, r);
            end
        end
    endtask

    task automatic expect_silence(input int r);
        for (int k = 0; k < SILENT_EDGES; k++) begin
            next_edge();
            checks++;
            if (spi_d_oe !== 1'b0) begin
                errors++;
                $display("MISMATCH at %0t: row %0d spi_d_oe high after a silent command",
                         $time, r);
            end
        end
    endtask

    // Drop chip select mid-stream, then outputs must stay low
    task automatic cut_selection(input int r);
        @(posedge ice_st_spi_clk);
        spi_cs <= 1'b0;
        repeat (3) begin
            @(negedge ice_st_spi_clk);
            checks++;
            if (spi_d_oe !== 1'b0 || spi_d_ready !== 1'b0) begin
                errors++;
                $display("MISMATCH at %0t: row %0d oe=%b ready=%b with chip select low",
                         $time, r, spi_d_oe, spi_d_ready);
            end
        end
    endtask

    task automatic stream_chunks(input int r, input int chunks, input int cut);
        int   low_edges;
        logic ready_seen;
        for (int c = 0; c < chunks; c++) begin
            low_edges  = 0;
            ready_seen = 1'b0;
            next_edge();
            while (spi_d_oe !== 1'b1 && low_edges < START_LIMIT) begin
                ready_seen = ready_seen | spi_d_ready;
                low_edges++;
                next_edge();
            end
            if (spi_d_oe !== 1'b1) begin
                errors++;
                $display("ERROR at %0t: row %0d chunk %0d never started streaming",
                         $time, r, c);
                return;
            end
            if (c == 0) begin
                checks++;
                if (!ready_seen) begin
                    errors++;
                    $display("MISMATCH at %0t: row %0d spi_d_ready low before the first byte",
                             $time, r);
                end
            end else begin
                checks++;
                if (low_edges < CHUNK_GAP) begin
                    errors++;
                    $display("MISMATCH at %0t: row %0d gap of %0d cycles, expected at least %0d",
                             $time, r, low_edges, CHUNK_GAP);
                end
            end
            for (int b = 0; b < CHUNK_LEN; b++) begin
                if (b > 0) next_edge();
                if (c == chunks - 1 && b == cut) begin
                    cut_selection(r);
                    return;
                end
                checks++;
                if (spi_d_oe !== 1'b1 || spi_d_out !== byte_t'(b)) begin
                    errors++;
                    $display("MISMATCH at %0t: row %0d chunk %0d byte %0d got oe=%b data=%h",
                             $time, r, c, b, spi_d_oe, spi_d_out);
                end
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        spi_cs   <= 1'b0;
        spi_d_in <= '0;
        seed     = 79;
        errors   = 0;
        checks   = 0;
        fill_table();
        repeat (3) @(posedge ice_st_spi_clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r > 0) hold_deselect();
            send_command(row_type[r], row_arg[r]);
            case (row_kind[r])
                ROW_ECHO:   expect_echo(r, row_arg[r]);
                ROW_SILENT: expect_silence(r);
                default:    stream_chunks(r, row_chunks[r], row_cut[r]);
            endcase
        end
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_engine.u_asserts.fail_count);
        if (errors == 0 && UUT.u_engine.u_asserts.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
ice_app_pkg.sv
afifo.sv
chunk_producer.sv
spi_msg_engine.sv
ice_app_top.sv
ice_app_asserts.sv
tb_ice_app.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_ice_app
./obj_dir/Vtb_ice_app | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
